// ==== sources.f ====
logic/uartPkg.sv
logic/baudGen.sv
logic/uartTx.sv
logic/uartRx.sv
logic/selfTest.sv
logic/rxFifo.sv
logic/uartTop.sv
test/uartTopTb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --assert --top-module uartTopTb -f sources.f -o uartSim &&
./obj_dir/uartSim ||
exit 1

// ==== test/uartTopTb.sv ====
`default_nettype none

module uartTopTb;

	// **************************************************
	// Timing derived from the frame format
	// **************************************************
	localparam int bitCycles = uartPkg::clkPerTick * uartPkg::ticksPerBit;	// 64
	localparam int frameCycles = 10 * bitCycles;		// Start, 8 data, stop
	localparam int nScen = 7;
	localparam int timeoutCycles = nScen * 12 * frameCycles;

	typedef enum logic [1:0] {
		kRx,		// Frame into rx and read from FIFO
		kTx,		// Host byte out on tx
		kFull,		// Nine frames until overflow
		kBist		// Loopback self test
	} kind_t;

	typedef struct packed {
		kind_t kind;
		uartPkg::uartByte_t data;
		logic badStop;		// Drive stop bit low
		logic ctsOn;		// cts level at the strobe
	} scenario_t;

	logic sysClk = 1'b0;
	logic rst;
	logic rx;
	logic cts;
	uartPkg::uartByte_t txData;
	logic txStart;
	logic pop;
	logic bistStart;
	logic tx;
	uartPkg::rxWord_t rxWord;
	uartPkg::uartStatus_t status;

	scenario_t scenarios [nScen];
	logic [15:0] lfsrState = 16'd17;
	int cycleCount = 0;

	uartTop i_uartTop (
		.sysClk,
		.rst,
		.rx,
		.cts,
		.txData,
		.txStart,
		.pop,
		.bistStart,
		.tx,
		.rxWord,
		.status
	);

	always #50 sysClk = ~sysClk;		// Period 100

	// Hang guard
	always @(posedge sysClk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutCycles) begin
			$display("TEST FAILED");
			$fatal(1, "Timeout: the run did not finish within %0d cycles", timeoutCycles);
		end
	end

	// **************************************************
	// Compare tasks
	// **************************************************
	task automatic checkWord(input uartPkg::rxWord_t got, input uartPkg::rxWord_t exp,
			input string msg);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %h expected %h", $time, msg, got, exp);
			$display("TEST FAILED");
			$fatal(1, "Received word check failed");
		end
	endtask

	task automatic checkStatus(input uartPkg::uartStatus_t got,
			input uartPkg::uartStatus_t exp, input string msg);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %b expected %b", $time, msg, got, exp);
			$display("TEST FAILED");
			$fatal(1, "Status check failed");
		end
	endtask

	task automatic checkByte(input uartPkg::uartByte_t got, input uartPkg::uartByte_t exp,
			input string msg);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %h expected %h", $time, msg, got, exp);
			$display("TEST FAILED");
			$fatal(1, "Byte check failed");
		end
	endtask

	task automatic checkLine(input logic got, input logic exp, input string msg);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %b expected %b", $time, msg, got, exp);
			$display("TEST FAILED");
			$fatal(1, "Single bit check failed");
		end
	endtask

	// Flags straight after reset
	function automatic uartPkg::uartStatus_t idleStatus();
		uartPkg::uartStatus_t s;
		s = '0;
		s.fifoEmpty = 1'b1;
		return s;
	endfunction

	// x^16 + x^14 + x^13 + x^11
	function automatic logic [15:0] lfsrStep(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic randByte(output uartPkg::uartByte_t b);
		int i;
		for (i = 0; i < uartPkg::dataBits; i++) begin
			lfsrState = lfsrStep(lfsrState);		// One step per bit
			b[i] = lfsrState[0];
		end
	endtask

	// **************************************************
	// Line models and host strobes
	// **************************************************
	task automatic resetDut();
		@(posedge sysClk);
		rst <= 1'b1;
		rx <= 1'b1;
		cts <= 1'b1;
		txStart <= 1'b0;
		pop <= 1'b0;
		bistStart <= 1'b0;
		repeat (16) @(posedge sysClk);
		rst <= 1'b0;
		@(negedge sysClk);
		checkStatus(status, idleStatus(), "status after reset");
		checkLine(tx, 1'b1, "tx after reset");
	endtask

	// Serial driver with one idle bit after the stop bit
	task automatic sendFrame(input uartPkg::uartByte_t b, input logic badStop);
		logic [9:0] frame;
		int i;
		frame = {!badStop, b, 1'b0};		// Shifted out LSB first
		for (i = 0; i < 10; i++) begin
			@(posedge sysClk);
			rx <= frame[i];
			repeat (bitCycles - 1) @(posedge sysClk);
		end
		@(posedge sysClk);
		rx <= 1'b1;
		repeat (bitCycles - 1) @(posedge sysClk);
	endtask

	task automatic popWord();
		@(posedge sysClk);
		pop <= 1'b1;
		@(posedge sysClk);
		pop <= 1'b0;
	endtask

	// Monitor sampling tx at mid-bit
	task automatic readTx(output uartPkg::uartByte_t b);
		int i;
		while (tx) @(negedge sysClk);		// Start bit edge
		repeat (bitCycles / 2) @(negedge sysClk);
		checkLine(tx, 1'b0, "tx start bit");
		for (i = 0; i < uartPkg::dataBits; i++) begin
			repeat (bitCycles) @(negedge sysClk);
			b[i] = tx;
			checkLine(status.txBusy, 1'b1, "txBusy in data bit");
		end
		repeat (bitCycles) @(negedge sysClk);
		checkLine(tx, 1'b1, "tx stop bit");
		checkLine(status.txBusy, 1'b1, "txBusy in stop bit");
	endtask

	// **************************************************
	// Scenario runners
	// **************************************************
	task automatic runRx(input scenario_t sc);
		uartPkg::rxWord_t expWord;
		uartPkg::uartStatus_t exp;
		expWord.data = sc.data;
		expWord.frameErr = sc.badStop;
		@(posedge sysClk);
		cts <= sc.ctsOn;
		sendFrame(sc.data, sc.badStop);
		@(negedge sysClk);
		while (status.fifoEmpty) @(negedge sysClk);
		checkWord(rxWord, expWord, "FIFO head");
		exp = idleStatus();
		exp.fifoEmpty = 1'b0;
		exp.rxError = sc.badStop;
		checkStatus(status, exp, "status with one word");
		popWord();
		@(negedge sysClk);
		exp.fifoEmpty = 1'b1;		// rxError holds
		checkStatus(status, exp, "status after pop");
	endtask

	task automatic runTx(input scenario_t sc);
		uartPkg::uartStatus_t exp;
		uartPkg::uartByte_t got;
		@(posedge sysClk);
		txData <= sc.data;
		txStart <= 1'b1;
		cts <= sc.ctsOn;
		if (!sc.ctsOn) begin
			// Strobe held so nothing may go out
			repeat (2 * bitCycles) begin
				@(negedge sysClk);
				checkLine(tx, 1'b1, "tx while cts low");
				checkStatus(status, idleStatus(), "status while cts low");
			end
			@(posedge sysClk);
			cts <= 1'b1;
		end
		@(posedge sysClk);		// Accepted here
		txStart <= 1'b0;
		@(negedge sysClk);
		exp = idleStatus();
		exp.txBusy = 1'b1;
		checkStatus(status, exp, "txBusy after acceptance");
		readTx(got);
		checkByte(got, sc.data, "decoded tx byte");
		while (status.txBusy) @(negedge sysClk);
		checkStatus(status, idleStatus(), "status after frame");
	endtask

	task automatic runFull();
		uartPkg::uartByte_t expQ[$];
		uartPkg::uartByte_t b;
		uartPkg::rxWord_t expWord;
		uartPkg::uartStatus_t exp;
		int i;
		exp = idleStatus();
		exp.fifoEmpty = 1'b0;
		for (i = 0; i <= uartPkg::fifoDepth; i++) begin
			randByte(b);
			if (i < uartPkg::fifoDepth) expQ.push_back(b);		// Ninth is dropped
			sendFrame(b, 1'b0);
			if (i == uartPkg::fifoDepth - 1) begin
				@(negedge sysClk);
				exp.fifoFull = 1'b1;
				checkStatus(status, exp, "full without overflow");
			end
		end
		@(negedge sysClk);
		exp.fifoOverflow = 1'b1;
		checkStatus(status, exp, "full with overflow");
		expWord.frameErr = 1'b0;
		for (i = 0; i < uartPkg::fifoDepth; i++) begin
			@(negedge sysClk);
			expWord.data = expQ.pop_front();
			checkWord(rxWord, expWord, "head in arrival order");
			popWord();
		end
		@(negedge sysClk);
		exp.fifoEmpty = 1'b1;
		exp.fifoFull = 1'b0;
		checkStatus(status, exp, "drained, overflow sticky");
	endtask

	task automatic runBist();
		uartPkg::uartByte_t seed;
		uartPkg::uartStatus_t exp;
		randByte(seed);
		@(posedge sysClk);
		txData <= seed;
		bistStart <= 1'b1;
		@(posedge sysClk);
		bistStart <= 1'b0;
		@(negedge sysClk);
		exp = idleStatus();
		exp.bistBusy = 1'b1;
		checkStatus(status, exp, "self test started");
		while (status.bistBusy) begin
			checkLine(status.fifoEmpty, 1'b1, "FIFO empty in self test");
			@(negedge sysClk);
		end
		checkLine(status.bistError, 1'b0, "bistError at end");
		checkLine(status.rxError, 1'b0, "rxError at end");
		checkLine(status.fifoEmpty, 1'b1, "FIFO empty at end");
		while (status.txBusy) @(negedge sysClk);		// Stop bit drains
		checkStatus(status, idleStatus(), "status after self test");
	endtask

	// **************************************************
	// Main sequence
	// **************************************************
	initial begin
		int n;
		rst <= 1'b1;
		rx <= 1'b1;
		cts <= 1'b1;
		txData <= '0;
		txStart <= 1'b0;
		pop <= 1'b0;
		bistStart <= 1'b0;
		scenarios = '{
			'{kRx, 8'hA5, 1'b0, 1'b1},
			'{kRx, 8'h3C, 1'b1, 1'b1},		// Framing error
			'{kRx, 8'h81, 1'b0, 1'b1},
			'{kTx, 8'h5A, 1'b0, 1'b1},
			'{kTx, 8'hC3, 1'b0, 1'b0},		// Held off by cts
			'{kFull, 8'h00, 1'b0, 1'b1},
			'{kBist, 8'h00, 1'b0, 1'b1}
		};
		for (n = 0; n < nScen; n++) begin
			resetDut();
			case (scenarios[n].kind)
				kRx: runRx(scenarios[n]);
				kTx: runTx(scenarios[n]);
				kFull: runFull();
				default: runBist();
			endcase
		end
		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

// ==== logic/uartTop.sv ====
`default_nettype none

module uartTop (
	input wire sysClk,
	input wire rst,
	input wire rx,
	input wire cts,
	input wire uartPkg::uartByte_t txData,
	input wire txStart,
	input wire pop,
	input wire bistStart,
	output logic tx,
	output uartPkg::rxWord_t rxWord,
	output uartPkg::uartStatus_t status
);

	logic tick;
	logic txBusy;
	logic rxDone;
	logic rxError;
	logic bistMode;			// Selects loopback
	logic bistTxStart;
	logic bistBusy;
	logic bistError;
	logic fifoEmpty;
	logic fifoFull;
	logic fifoOverflow;
	logic txStartSel;
	logic rxSel;
	uartPkg::uartByte_t bistTxData;
	uartPkg::uartByte_t txDataSel;
	uartPkg::rxWord_t rxOut;

	// **************************************************
	// Loopback muxes
	// **************************************************
	assign txDataSel = bistMode ? bistTxData : txData;
	assign txStartSel = bistMode ? bistTxStart : txStart;
	assign rxSel = bistMode ? tx : rx;		// Own line back in

	// Host status
	assign status = '{
		txBusy: txBusy,
		rxError: rxError,
		fifoEmpty: fifoEmpty,
		fifoFull: fifoFull,
		fifoOverflow: fifoOverflow,
		bistBusy: bistBusy,
		bistError: bistError
	};

	baudGen i_baudGen (.sysClk, .rst, .tick);

	uartTx i_uartTx (
		.sysClk,
		.rst,
		.tick,
		.data(txDataSel),
		.start(txStartSel),
		.cts,
		.tx,			// Port always shows the line
		.txBusy
	);

	uartRx i_uartRx (.sysClk, .rst, .tick, .rx(rxSel), .rxDone, .rxOut, .rxError);

	selfTest i_selfTest (
		.sysClk,
		.rst,
		.bistStart,
		.seed(txData),
		.rxDone,
		.rxIn(rxOut),
		.txBusy,
		.bistMode,
		.bistTxData,
		.bistTxStart,
		.bistBusy,
		.bistError
	);

	rxFifo i_rxFifo (
		.sysClk,
		.rst,
		.wrEn(rxDone),
		.wrData(rxOut),
		.bistMode,		// Blocks loopback writes
		.pop,
		.head(rxWord),
		.fifoEmpty,
		.fifoFull,
		.fifoOverflow
	);

endmodule

`default_nettype wire

// ==== logic/rxFifo.sv ====
`default_nettype none

module rxFifo (
	input wire sysClk,
	input wire rst,
	input wire wrEn,
	input wire uartPkg::rxWord_t wrData,
	input wire bistMode,
	input wire pop,
	output uartPkg::rxWord_t head,
	output logic fifoEmpty,
	output logic fifoFull,
	output logic fifoOverflow
);

	uartPkg::rxWord_t mem [uartPkg::fifoDepth];
	logic [uartPkg::ptrBits-1:0] rdPtr;
	logic [uartPkg::ptrBits-1:0] wrPtr;
	logic [uartPkg::occBits-1:0] occ;		// Entries held
	logic wrOk;
	logic popOk;

	assign fifoEmpty = (occ == '0);
	assign fifoFull = (occ == uartPkg::fifoFullCnt);
	assign wrOk = wrEn && !bistMode && !fifoFull;	// Loopback bytes stay internal
	assign popOk = pop && !fifoEmpty;
	assign head = mem[rdPtr];		// Show-ahead

	// **************************************************
	// Storage
	// **************************************************
	always_ff @(posedge sysClk) begin
		if (wrOk) mem[wrPtr] <= wrData;
	end

	// Pointers, occupancy and overflow
	always_ff @(posedge sysClk) begin
		if (rst) begin
			rdPtr <= '0;
			wrPtr <= '0;
			occ <= '0;
			fifoOverflow <= 1'b0;
		end else begin
			if (wrOk) wrPtr <= wrPtr + 1'b1;		// Power of two depth wraps
			if (popOk) rdPtr <= rdPtr + 1'b1;
			case ({wrOk, popOk})
				2'b10: occ <= occ + 1'b1;
				2'b01: occ <= occ - 1'b1;
				default: occ <= occ;		// Both or neither
			endcase
			if (wrEn && !bistMode && fifoFull) begin
				fifoOverflow <= 1'b1;		// Word dropped
			end
		end
	end

	occBounded: assert property (
		@(posedge sysClk) disable iff (rst)
		occ <= uartPkg::fifoFullCnt
	);

endmodule

`default_nettype wire

// ==== logic/selfTest.sv ====
`default_nettype none

module selfTest (
	input wire sysClk,
	input wire rst,
	input wire bistStart,
	input wire uartPkg::uartByte_t seed,
	input wire rxDone,
	input wire uartPkg::rxWord_t rxIn,
	input wire txBusy,
	output logic bistMode,
	output uartPkg::uartByte_t bistTxData,
	output logic bistTxStart,
	output logic bistBusy,
	output logic bistError
);

	typedef enum logic [2:0] {
		sIdle,
		sWaitTx,		// Transmitter still finishing
		sStrobe,		// Start strobe out
		sCheck,			// Did the transmitter take it
		sWaitRx			// Loopback byte in flight
	} bistState_t;

	bistState_t state;
	logic byteIdx;				// 0 seed, 1 complement
	uartPkg::uartByte_t seedReg;

	// Byte under test
	assign bistTxData = byteIdx ? ~seedReg : seedReg;
	assign bistTxStart = (state == sStrobe);
	assign bistBusy = (state != sIdle);
	assign bistMode = bistBusy;		// Loopback for the whole run

	// **************************************************
	// Test sequencer
	// **************************************************
	always_ff @(posedge sysClk) begin
		if (rst) begin
			state <= sIdle;
			byteIdx <= 1'b0;
			bistError <= 1'b0;
		end else begin
			case (state)
				sIdle: begin
					if (bistStart) begin
						seedReg <= seed;
						byteIdx <= 1'b0;
						bistError <= 1'b0;		// Fresh verdict per run
						state <= sWaitTx;
					end
				end
				sWaitTx: if (!txBusy) state <= sStrobe;
				sStrobe: state <= sCheck;
				sCheck: begin
					// Busy rises one cycle after acceptance
					// Retry if CTS held the strobe off
					state <= txBusy ? sWaitRx : sWaitTx;
				end
				sWaitRx: begin
					if (rxDone) begin
						if (rxIn.frameErr || (rxIn.data != bistTxData)) begin
							bistError <= 1'b1;		// Sticky until next start
						end
						if (byteIdx) begin
							state <= sIdle;		// Both bytes judged
						end else begin
							byteIdx <= 1'b1;
							state <= sWaitTx;
						end
					end
				end
				default: state <= sIdle;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== logic/uartRx.sv ====
`default_nettype none

module uartRx (
	input wire sysClk,
	input wire rst,
	input wire tick,
	input wire rx,
	output logic rxDone,
	output uartPkg::rxWord_t rxOut,
	output logic rxError
);

	typedef enum logic [1:0] {
		sIdle,
		sStart,
		sData,
		sStop
	} rxState_t;

	rxState_t state;
	logic [1:0] rxSync;			// Metastability chain
	logic rxLine;
	logic rxPrev;				// Line value at previous tick
	logic [uartPkg::tickCntBits-1:0] tickCnt;
	logic [uartPkg::bitCntBits-1:0] bitCnt;
	uartPkg::uartByte_t shiftReg;

	assign rxLine = rxSync[1];

	// **************************************************
	// Input synchronizer
	// **************************************************
	always_ff @(posedge sysClk) begin
		if (rst) begin
			rxSync <= 2'b11;		// Idle level
		end else begin
			rxSync <= {rxSync[0], rx};
		end
	end

	// **************************************************
	// Receive FSM
	// **************************************************
	always_ff @(posedge sysClk) begin
		rxDone <= 1'b0;		// Single cycle strobe
		if (rst) begin
			state <= sIdle;
			rxPrev <= 1'b1;
			tickCnt <= '0;
			bitCnt <= '0;
			rxError <= 1'b0;
		end else if (tick) begin
			rxPrev <= rxLine;
			case (state)
				sIdle: begin
					// Falling edge between two ticks
					if (rxPrev && !rxLine) begin
						tickCnt <= '0;
						state <= sStart;
					end
				end
				sStart: begin
					if (tickCnt == uartPkg::tickMid) begin
						tickCnt <= '0;
						bitCnt <= '0;
						state <= rxLine ? sIdle : sData;	// High at mid is a glitch
					end else begin
						tickCnt <= tickCnt + 1'b1;
					end
				end
				sData: begin
					if (tickCnt == uartPkg::tickLast) begin
						tickCnt <= '0;
						shiftReg <= {rxLine, shiftReg[uartPkg::dataBits-1:1]};	// LSB first
						if (bitCnt == uartPkg::bitLast) begin
							bitCnt <= '0;
							state <= sStop;
						end else begin
							bitCnt <= bitCnt + 1'b1;
						end
					end else begin
						tickCnt <= tickCnt + 1'b1;
					end
				end
				sStop: begin
					if (tickCnt == uartPkg::tickLast) begin
						tickCnt <= '0;
						if (bitCnt == uartPkg::stopLast) begin
							// Present word on the cycle after the sample
							rxDone <= 1'b1;
							rxOut.data <= shiftReg;
							rxOut.frameErr <= !rxLine;		// Stop bit read low
							rxError <= !rxLine;		// Held until next word
							state <= sIdle;
						end else begin
							bitCnt <= bitCnt + 1'b1;
						end
					end else begin
						tickCnt <= tickCnt + 1'b1;
					end
				end
				default: state <= sIdle;
			endcase
		end
	end

	// Downstream FIFO counts every high cycle as a write
	doneIsPulse: assert property (
		@(posedge sysClk) disable iff (rst)
		rxDone |=> !rxDone
	);

endmodule

`default_nettype wire

// ==== logic/uartTx.sv ====
`default_nettype none

module uartTx (
	input wire sysClk,
	input wire rst,
	input wire tick,
	input wire uartPkg::uartByte_t data,
	input wire start,
	input wire cts,
	output logic tx,
	output logic txBusy
);

	typedef enum logic [1:0] {
		sIdle,
		sStart,
		sData,
		sStop
	} txState_t;

	txState_t state;
	logic pending;				// Accepted and waiting for first tick
	logic [uartPkg::tickCntBits-1:0] tickCnt;
	logic [uartPkg::bitCntBits-1:0] bitCnt;
	uartPkg::uartByte_t shiftReg;

	assign txBusy = (state != sIdle);	// Rises the cycle after acceptance

	// **************************************************
	// Transmit FSM
	// **************************************************
	always_ff @(posedge sysClk) begin
		if (rst) begin
			state <= sIdle;
			pending <= 1'b0;
			tickCnt <= '0;
			bitCnt <= '0;
			tx <= 1'b1;		// Line idles high
		end else begin
			case (state)
				sIdle: begin
					tx <= 1'b1;
					// CTS only gates acceptance
					if (start && cts) begin
						shiftReg <= data;
						pending <= 1'b1;
						state <= sStart;
					end
				end
				sStart: if (tick) begin
					if (pending) begin
						pending <= 1'b0;
						tx <= 1'b0;		// Start bit edge
						tickCnt <= '0;
					end else if (tickCnt == uartPkg::tickLast) begin
						tickCnt <= '0;
						bitCnt <= '0;
						tx <= shiftReg[0];		// LSB first
						state <= sData;
					end else begin
						tickCnt <= tickCnt + 1'b1;
					end
				end
				sData: if (tick) begin
					if (tickCnt == uartPkg::tickLast) begin
						tickCnt <= '0;
						if (bitCnt == uartPkg::bitLast) begin
							bitCnt <= '0;
							tx <= 1'b1;		// Stop bit
							state <= sStop;
						end else begin
							bitCnt <= bitCnt + 1'b1;
							shiftReg <= shiftReg >> 1;
							tx <= shiftReg[1];	// Next bit before the shift lands
						end
					end else begin
						tickCnt <= tickCnt + 1'b1;
					end
				end
				sStop: if (tick) begin
					if (tickCnt == uartPkg::tickLast) begin
						tickCnt <= '0;
						if (bitCnt == uartPkg::stopLast) begin
							state <= sIdle;		// Busy drops here
						end else begin
							bitCnt <= bitCnt + 1'b1;
						end
					end else begin
						tickCnt <= tickCnt + 1'b1;
					end
				end
				default: state <= sIdle;
			endcase
		end
	end

	// Line stays marking outside a frame and while waiting for a tick
	idleLineHigh: assert property (
		@(posedge sysClk) disable iff (rst)
		!txBusy |-> tx
	);

endmodule

`default_nettype wire

// ==== logic/baudGen.sv ====
`default_nettype none

module baudGen (
	input wire sysClk,
	input wire rst,
	output logic tick		// One cycle every clkPerTick cycles
);

	logic [uartPkg::clkCntBits-1:0] clkCnt;

	// **************************************************
	// Modulo counter
	// **************************************************
	always_ff @(posedge sysClk) begin
		if (rst) begin
			clkCnt <= '0;
			tick <= 1'b0;
		end else if (clkCnt == uartPkg::clkLast) begin
			clkCnt <= '0;		// Wrap
			tick <= 1'b1;		// Registered so glitch free
		end else begin
			clkCnt <= clkCnt + 1'b1;
			tick <= 1'b0;
		end
	end

	// Tick is an enable and never a level
	tickIsPulse: assert property (
		@(posedge sysClk) disable iff (rst)
		tick |=> !tick
	);

endmodule

`default_nettype wire

// ==== logic/uartPkg.sv ====
`default_nettype none

package uartPkg;

	// **************************************************
	// Rates and frame format
	// **************************************************
	localparam int clkPerTick = 4;		// sysClk cycles per oversampling tick
	localparam int ticksPerBit = 16;	// Ticks per serial bit
	localparam int dataBits = 8;
	localparam int stopBits = 1;
	localparam int fifoDepth = 8;		// Receive FIFO entries

	// Counter widths
	localparam int clkCntBits = $clog2(clkPerTick);
	localparam int tickCntBits = $clog2(ticksPerBit);
	localparam int bitCntBits = $clog2(dataBits);
	localparam int ptrBits = $clog2(fifoDepth);
	localparam int occBits = $clog2(fifoDepth + 1);	// Occupancy must reach fifoDepth

	// Terminal counts at counter width
	localparam logic [clkCntBits-1:0] clkLast = clkCntBits'(clkPerTick - 1);
	localparam logic [tickCntBits-1:0] tickLast = tickCntBits'(ticksPerBit - 1);
	localparam logic [tickCntBits-1:0] tickMid = tickCntBits'(ticksPerBit / 2 - 1);
	localparam logic [bitCntBits-1:0] bitLast = bitCntBits'(dataBits - 1);
	localparam logic [bitCntBits-1:0] stopLast = bitCntBits'(stopBits - 1);
	localparam logic [occBits-1:0] fifoFullCnt = occBits'(fifoDepth);

	// **************************************************
	// Payload types
	// **************************************************
	typedef logic [dataBits-1:0] uartByte_t;

	// One received frame
	typedef struct packed {
		uartByte_t data;
		logic frameErr;		// Stop bit read low
	} rxWord_t;

	// Host status flags
	typedef struct packed {
		logic txBusy;
		logic rxError;
		logic fifoEmpty;
		logic fifoFull;
		logic fifoOverflow;
		logic bistBusy;
		logic bistError;
	} uartStatus_t;

endpackage

`default_nettype wire
